// File: include/vlsu_cfg.svh
`ifndef VLSU_CFG_SVH
`define VLSU_CFG_SVH

// byte address width of the data memory port
`define VLSU_ADDR_W 32

// width of one memory word and of one vector register element slot
`define VLSU_DATA_W 32

// largest vector length a single command may request
`define VLSU_VLMAX 32

// element index width, one bit wider than needed for indices below vlmax
// so that vl itself and the index just past the last pair fit
`define VLSU_IDX_W 6

// number of byte lanes in one memory word
`define VLSU_BYTES (`VLSU_DATA_W / 8)

// element sizes in bytes, used when a stride is given for unit-stride access
`define VLSU_SIZE8  1
`define VLSU_SIZE16 2
`define VLSU_SIZE32 4

`endif

// File: rtl/vlsu_pkg.sv
`default_nettype none

`include "vlsu_cfg.svh"

package vlsu_pkg;

  // element width of a load or store, as encoded in the instruction
  typedef enum logic [1:0] {
    WIDTH8  = 2'd0,
    WIDTH16 = 2'd1,
    WIDTH32 = 2'd2
  } eew_t;

  // one vector memory command, unit-stride uses the element size as stride
  typedef struct packed {
    logic                   store;
    eew_t                   eew;
    logic [`VLSU_ADDR_W-1:0] base;
    logic [`VLSU_ADDR_W-1:0] stride;
    logic [`VLSU_IDX_W-1:0]  vl;
  } vlsu_cmd_t;

  // two neighbouring elements offered together by the address generator
  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0] addr0;
    logic [`VLSU_ADDR_W-1:0] addr1;
    logic [`VLSU_DATA_W-1:0] data0;
    logic [`VLSU_DATA_W-1:0] data1;
    logic [`VLSU_IDX_W-1:0]  idx0;
    logic [`VLSU_IDX_W-1:0]  idx1;
    logic                    valid1;
    logic                    store;
    eew_t                    eew;
  } elem_pair_t;

  // request on the word-wide data memory port
  typedef struct packed {
    logic [`VLSU_ADDR_W-1:0]  addr;
    logic [`VLSU_DATA_W-1:0]  wdata;
    logic [`VLSU_BYTES-1:0]   byte_en;
    logic                     ren;
    logic                     wen;
  } mem_req_t;

  // single element write into the vector register file
  typedef struct packed {
    logic                    wen;
    logic [`VLSU_IDX_W-1:0]  idx;
    logic [`VLSU_DATA_W-1:0] data;
  } vreg_wr_t;

endpackage

`default_nettype wire

// File: rtl/vlsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_cfg.svh"

module vlsu_addr_gen import vlsu_pkg::*;
(
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    cmd_start,
  input  wire vlsu_cmd_t               cmd,
  input  wire logic                    ex_clear,
  input  wire logic                    pair_done,
  output logic [`VLSU_IDX_W-1:0]       vs_idx0,
  output logic [`VLSU_IDX_W-1:0]       vs_idx1,
  input  wire logic [`VLSU_DATA_W-1:0] vs_data0,
  input  wire logic [`VLSU_DATA_W-1:0] vs_data1,
  output elem_pair_t                   pair,
  output logic                         pair_ena,
  output logic                         last
);

  // active is set while a command is held, it doubles as the pair level
  logic                    active;
  vlsu_cmd_t               cmd_q;
  logic [`VLSU_IDX_W-1:0]  cnt;
  logic [`VLSU_IDX_W-1:0]  idx1;
  logic [`VLSU_IDX_W-1:0]  vl_lim;
  logic [`VLSU_ADDR_W-1:0] idx0_ext;
  logic [`VLSU_ADDR_W-1:0] idx1_ext;
  logic                    valid1;

  // a vl above the hardware maximum is cut down to vlmax when taken
  assign vl_lim = (cmd.vl > `VLSU_IDX_W'(`VLSU_VLMAX)) ? `VLSU_IDX_W'(`VLSU_VLMAX) : cmd.vl;

  // the counter always points at the first element of the current pair
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      active <= 1'b0;
      cnt    <= '0;
    end
    else if (!active)
    begin
      // a new command is only taken while nothing is in flight
      if (cmd_start)
      begin
        active <= 1'b1;
        cnt    <= '0;
      end
    end
    else if (ex_clear)
    begin
      // the faulting command is dropped, software restarts it if needed
      active <= 1'b0;
    end
    else if (pair_done)
    begin
      cnt <= cnt + `VLSU_IDX_W'(2);
      if (last)
        active <= 1'b0;
    end
  end

  // the command itself is plain payload, captured with the start pulse
  always_ff @(posedge CLK)
  begin
    if (!active && cmd_start)
    begin
      cmd_q    <= cmd;
      cmd_q.vl <= vl_lim;
    end
  end

  assign idx1   = cnt + `VLSU_IDX_W'(1);
  assign valid1 = (idx1 < cmd_q.vl);

  // this pair is the final one when the next pair would start at or past vl
  assign last = ((cnt + `VLSU_IDX_W'(2)) >= cmd_q.vl);

  // indices widened to address width before the stride multiply
  assign idx0_ext = {{(`VLSU_ADDR_W-`VLSU_IDX_W){1'b0}}, cnt};
  assign idx1_ext = {{(`VLSU_ADDR_W-`VLSU_IDX_W){1'b0}}, idx1};

  // register file read ports are combinational with no latency
  // the second port stays on element 0 when element 1 lies past vl
  assign vs_idx0 = cnt;
  assign vs_idx1 = valid1 ? idx1 : cnt;

  always_comb
  begin
    pair.addr0  = cmd_q.base + idx0_ext * cmd_q.stride;
    pair.addr1  = cmd_q.base + idx1_ext * cmd_q.stride;
    pair.data0  = vs_data0;
    pair.data1  = vs_data1;
    pair.idx0   = cnt;
    pair.idx1   = idx1;
    pair.valid1 = valid1;
    pair.store  = cmd_q.store;
    pair.eew    = cmd_q.eew;
  end

  assign pair_ena = active;

endmodule

`default_nettype wire

// File: rtl/address_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_cfg.svh"

module address_scheduler import vlsu_pkg::*;
(
  input  wire logic               CLK,
  input  wire logic               nRST,
  input  wire elem_pair_t         pair,
  input  wire logic               pair_ena,
  input  wire logic               last,
  input  wire logic               ex_clear,
  input  wire logic               mem_hit,
  output mem_req_t                mem_req,
  output logic                    pair_done,
  output logic                    arrived,
  output logic [1:0]              arr_addr,
  output logic [`VLSU_IDX_W-1:0]  arr_idx,
  output logic                    busy,
  output logic                    done,
  output logic                    exception
);

  typedef enum logic [1:0] {IDLE, ACC0, ACC1, EX} state_t;

  state_t state, next_state;

  logic                    misalign0;
  logic                    misalign1;
  logic                    access;
  logic [`VLSU_ADDR_W-1:0] cur_addr;
  logic [`VLSU_DATA_W-1:0] cur_data;
  logic [`VLSU_IDX_W-1:0]  cur_idx;
  logic [`VLSU_BYTES-1:0]  be_base;

  // element alignment against its own width, byte elements never fault
  always_comb
  begin
    misalign0 = 1'b0;
    misalign1 = 1'b0;
    case (pair.eew)
      WIDTH16:
      begin
        misalign0 = pair.addr0[0];
        misalign1 = pair.addr1[0];
      end
      WIDTH32:
      begin
        misalign0 = |pair.addr0[1:0];
        misalign1 = |pair.addr1[1:0];
      end
      default:
      begin
        misalign0 = 1'b0;
        misalign1 = 1'b0;
      end
    endcase
    // element 1 only counts when the pair will really issue it
    misalign1 = misalign1 & pair.valid1;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        // a bad pair is caught here so no part of it reaches memory
        if (pair_ena)
          next_state = (misalign0 || misalign1) ? EX : ACC0;
      end
      ACC0:
      begin
        if (mem_hit)
          next_state = pair.valid1 ? ACC1 : IDLE;
      end
      ACC1:
      begin
        if (mem_hit)
          next_state = IDLE;
      end
      EX:
      begin
        if (ex_clear)
          next_state = IDLE;
      end
      default:
        next_state = IDLE;
    endcase
  end

  assign access = (state == ACC0) || (state == ACC1);

  // pick the element that is on the port right now
  assign cur_addr = (state == ACC1) ? pair.addr1 : pair.addr0;
  assign cur_data = (state == ACC1) ? pair.data1 : pair.data0;
  assign cur_idx  = (state == ACC1) ? pair.idx1  : pair.idx0;

  // lane mask for an element that sits at byte 0 of the word
  always_comb
  begin
    case (pair.eew)
      WIDTH32: be_base = 4'b1111;
      WIDTH16: be_base = 4'b0011;
      default: be_base = 4'b0001;
    endcase
  end

  // request is fully combinational from state and pair, both stay put
  // while the memory has not hit, so the request is stable as required
  always_comb
  begin
    mem_req = '0;
    if (access)
    begin
      mem_req.addr    = cur_addr;
      mem_req.byte_en = be_base << cur_addr[1:0];
      mem_req.wdata   = cur_data << {cur_addr[1:0], 3'b000};
      mem_req.ren     = !pair.store;
      mem_req.wen     = pair.store;
    end
  end

  // a pair finishes on element 0 when there is no element 1
  assign pair_done = mem_hit && ((state == ACC1) || ((state == ACC0) && !pair.valid1));

  assign arrived  = access && mem_hit && !pair.store;
  assign arr_addr = cur_addr[1:0];
  assign arr_idx  = cur_idx;

  // busy covers a pending pair too, so it rises the cycle after a start
  assign busy      = access || ((state == IDLE) && pair_ena);
  assign exception = (state == EX);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      done <= 1'b0;
    else
      done <= pair_done && last;
  end

endmodule

`default_nettype wire

// File: rtl/vlsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_cfg.svh"

module vlsu_load_align import vlsu_pkg::*;
(
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    arrived,
  input  wire logic [1:0]              arr_addr,
  input  wire logic [`VLSU_IDX_W-1:0]  arr_idx,
  input  wire eew_t                    eew,
  input  wire logic [`VLSU_DATA_W-1:0] mem_rdata,
  output vreg_wr_t                     vreg_wr
);

  logic [`VLSU_DATA_W-1:0] shifted;
  logic [`VLSU_DATA_W-1:0] elem;
  logic                    wen_q;
  logic [`VLSU_IDX_W-1:0]  idx_q;
  logic [`VLSU_DATA_W-1:0] data_q;

  // bring the addressed byte lane down to bit 0
  assign shifted = mem_rdata >> {arr_addr, 3'b000};

  // loads are zero extended, there is no signed variant in this unit
  always_comb
  begin
    case (eew)
      WIDTH32: elem = shifted;
      WIDTH16: elem = {{(`VLSU_DATA_W-16){1'b0}}, shifted[15:0]};
      default: elem = {{(`VLSU_DATA_W-8){1'b0}}, shifted[7:0]};
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      wen_q <= 1'b0;
    else
      wen_q <= arrived;
  end

  // index and value are only looked at while the write strobe is high
  always_ff @(posedge CLK)
  begin
    if (arrived)
    begin
      idx_q  <= arr_idx;
      data_q <= elem;
    end
  end

  assign vreg_wr.wen  = wen_q;
  assign vreg_wr.idx  = idx_q;
  assign vreg_wr.data = data_q;

endmodule

`default_nettype wire

// File: rtl/vlsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_cfg.svh"

module vlsu import vlsu_pkg::*;
(
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    cmd_start,
  input  wire vlsu_cmd_t               cmd,
  output logic                         busy,
  output logic                         done,
  output logic                         exception,
  input  wire logic                    ex_clear,
  output logic [`VLSU_IDX_W-1:0]       vs_idx0,
  output logic [`VLSU_IDX_W-1:0]       vs_idx1,
  input  wire logic [`VLSU_DATA_W-1:0] vs_data0,
  input  wire logic [`VLSU_DATA_W-1:0] vs_data1,
  output vreg_wr_t                     vreg_wr,
  output mem_req_t                     mem_req,
  input  wire logic [`VLSU_DATA_W-1:0] mem_rdata,
  input  wire logic                    mem_hit
);

  elem_pair_t             pair;
  logic                   pair_ena;
  logic                   last;
  logic                   pair_done;
  logic                   arrived;
  logic [1:0]             arr_addr;
  logic [`VLSU_IDX_W-1:0] arr_idx;

  // walks the elements two at a time and reads the store sources
  vlsu_addr_gen u_addr_gen (
    .CLK       (CLK),
    .nRST      (nRST),
    .cmd_start (cmd_start),
    .cmd       (cmd),
    .ex_clear  (ex_clear),
    .pair_done (pair_done),
    .vs_idx0   (vs_idx0),
    .vs_idx1   (vs_idx1),
    .vs_data0  (vs_data0),
    .vs_data1  (vs_data1),
    .pair      (pair),
    .pair_ena  (pair_ena),
    .last      (last)
  );

  // serializes each pair onto the single memory port
  address_scheduler u_sched (
    .CLK       (CLK),
    .nRST      (nRST),
    .pair      (pair),
    .pair_ena  (pair_ena),
    .last      (last),
    .ex_clear  (ex_clear),
    .mem_hit   (mem_hit),
    .mem_req   (mem_req),
    .pair_done (pair_done),
    .arrived   (arrived),
    .arr_addr  (arr_addr),
    .arr_idx   (arr_idx),
    .busy      (busy),
    .done      (done),
    .exception (exception)
  );

  // load data goes back to the register file one cycle after the hit
  vlsu_load_align u_load_align (
    .CLK       (CLK),
    .nRST      (nRST),
    .arrived   (arrived),
    .arr_addr  (arr_addr),
    .arr_idx   (arr_idx),
    .eew       (pair.eew),
    .mem_rdata (mem_rdata),
    .vreg_wr   (vreg_wr)
  );

endmodule

`default_nettype wire

// File: testbench/tb_vlsu_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_cfg.svh"

module tb_vlsu_mem import vlsu_pkg::*;
(
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire mem_req_t                mem_req,
  output logic [`VLSU_DATA_W-1:0]      mem_rdata,
  output logic                         mem_hit
);

  localparam int MEM_BYTES = 1024;

  logic [7:0]              mem [0:MEM_BYTES-1];
  logic [`VLSU_ADDR_W-1:0] log_addr [0:255];
  logic [`VLSU_BYTES-1:0]  log_be [0:255];
  logic [1:0]              log_rw [0:255];
  int                      log_cnt = 0;
  logic [31:0]             lfsr = 32'h8e16_3956;
  logic                    preset_done = 1'b0;
  logic                    pending = 1'b0;
  int                      wait_left = 0;
  logic [31:0]             rnd;
  logic [9:0]              word_a;

  // galois lfsr that takes one step per bit handed out
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // the port stays quiet until the model first runs
  initial
  begin
    mem_hit   = 1'b0;
    mem_rdata = '0;
  end

  // the model answers 1 ns after the edge like the rest of the stimulus
  always @(posedge CLK)
  begin
    #1;
    if (!nRST)
    begin
      // contents are filled once in the first reset cycle
      if (!preset_done)
      begin
        for (int a = 0; a < MEM_BYTES; a++)
        begin
          rnd          = lfsr_bits(8);
          mem[10'(a)]  = rnd[7:0];
        end
        preset_done = 1'b1;
      end
      mem_hit   = 1'b0;
      mem_rdata = '0;
      pending   = 1'b0;
      log_cnt   = 0;
    end
    else
    begin
      mem_hit = 1'b0;
      if (mem_req.ren || mem_req.wen)
      begin
        // a fresh request draws its latency of 0 to 3 cycles
        if (!pending)
        begin
          pending   = 1'b1;
          rnd       = lfsr_bits(2);
          wait_left = int'(rnd[1:0]);
        end
        if (wait_left == 0)
        begin
          word_a = {mem_req.addr[9:2], 2'b00};
          for (int k = 0; k < `VLSU_BYTES; k++)
          begin
            if (mem_req.wen && mem_req.byte_en[k])
              mem[word_a + 10'(k)] = mem_req.wdata[8*k +: 8];
            mem_rdata[8*k +: 8] = mem[word_a + 10'(k)];
          end
          // every completed access goes into the log with its lanes and kind
          if (log_cnt < 256)
          begin
            log_addr[8'(log_cnt)] = mem_req.addr;
            log_be[8'(log_cnt)]   = mem_req.byte_en;
            log_rw[8'(log_cnt)]   = {mem_req.ren, mem_req.wen};
          end
          log_cnt = log_cnt + 1;
          mem_hit = 1'b1;
          pending = 1'b0;
        end
        else
          wait_left = wait_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_vlsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_cfg.svh"

module tb_vlsu import vlsu_pkg::*;
();

  localparam int VL_U32  = 12;
  localparam int VL_S8   = 10;
  localparam int VL_ST16 = 7;
  localparam int VL_BAD  = 4;
  localparam int VL_L16  = 5;
  // the overlapping start is never taken and adds no elements
  localparam int TOTAL_ELEMS    = VL_U32 + VL_S8 + VL_ST16 + VL_BAD + VL_L16;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_ELEMS + 200;

  logic                    CLK = 1'b0;
  logic                    nRST;
  logic                    cmd_start;
  logic                    ex_clear;
  vlsu_cmd_t               cmd;
  logic                    busy;
  logic                    done;
  logic                    exception;
  logic [`VLSU_IDX_W-1:0]  vs_idx0;
  logic [`VLSU_IDX_W-1:0]  vs_idx1;
  logic [`VLSU_DATA_W-1:0] vs_data0;
  logic [`VLSU_DATA_W-1:0] vs_data1;
  vreg_wr_t                vreg_wr;
  mem_req_t                mem_req;
  logic [`VLSU_DATA_W-1:0] mem_rdata;
  logic                    mem_hit;

  logic [`VLSU_DATA_W-1:0] vreg_src [0:`VLSU_VLMAX-1];
  logic [`VLSU_DATA_W-1:0] wr_val [0:`VLSU_VLMAX-1];
  int                      wr_count [0:`VLSU_VLMAX-1];
  logic [7:0]              ref_mem [0:1023];
  int                      cycle_cnt = 0;
  int                      done_cnt = 0;
  int                      started_cnt = 0;
  mem_req_t                prev_req;
  logic                    prev_pending = 1'b0;

  always #4 CLK = ~CLK;

  vlsu UUT (
    .CLK (CLK), .nRST (nRST), .cmd_start (cmd_start), .cmd (cmd),
    .busy (busy), .done (done), .exception (exception), .ex_clear (ex_clear),
    .vs_idx0 (vs_idx0), .vs_idx1 (vs_idx1), .vs_data0 (vs_data0), .vs_data1 (vs_data1),
    .vreg_wr (vreg_wr), .mem_req (mem_req), .mem_rdata (mem_rdata), .mem_hit (mem_hit)
  );

  tb_vlsu_mem u_mem (
    .CLK (CLK), .nRST (nRST), .mem_req (mem_req), .mem_rdata (mem_rdata), .mem_hit (mem_hit)
  );

  // register file read ports answer in the same cycle
  assign vs_data0 = vreg_src[vs_idx0[4:0]];
  assign vs_data1 = vreg_src[vs_idx1[4:0]];

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_hex(input string name, input logic [127:0] got, input logic [127:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      $display("check failed: %s", what);
      abort_run();
    end
  endtask

  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  function automatic int elem_bytes(input eew_t eew);
    return (eew == WIDTH32) ? `VLSU_SIZE32 :
           ((eew == WIDTH16) ? `VLSU_SIZE16 : `VLSU_SIZE8);
  endfunction

  function automatic vlsu_cmd_t make_cmd(input logic store, input eew_t eew,
                                         input logic [31:0] base, input logic [31:0] stride,
                                         input int vl);
    vlsu_cmd_t c;
    c.store  = store;
    c.eew    = eew;
    c.base   = base;
    c.stride = stride;
    c.vl     = `VLSU_IDX_W'(vl);
    return c;
  endfunction

  always @(posedge CLK)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // outputs are sampled at the falling edge where all of them have settled
  always @(negedge CLK)
  begin
    if (!nRST)
    begin
      prev_pending = 1'b0;
      for (int k = 0; k < `VLSU_VLMAX; k++)
        wr_count[5'(k)] = 0;
    end
    else
    begin
      // a stalled request must not move until its hit
      if (prev_pending)
        check_hex("mem_req", 128'(mem_req), 128'(prev_req));
      prev_req     = mem_req;
      prev_pending = (mem_req.ren || mem_req.wen) && !mem_hit;
      if (started_cnt > done_cnt && !done)
        check_true(busy, "busy fell while a command was still running");
      if (done)
      begin
        check_true(started_cnt > done_cnt, "done pulsed with no command in flight");
        check_true(!busy, "busy still high in the done cycle");
        done_cnt = done_cnt + 1;
      end
      if (vreg_wr.wen)
      begin
        check_true(vreg_wr.idx < `VLSU_IDX_W'(`VLSU_VLMAX), "register write past vlmax");
        wr_count[vreg_wr.idx[4:0]] = wr_count[vreg_wr.idx[4:0]] + 1;
        wr_val[vreg_wr.idx[4:0]]   = vreg_wr.data;
      end
    end
  end

  // runs one legal command and checks registers, memory and the access log
  task automatic run_cmd(input vlsu_cmd_t c, input logic overlap);
    int acc0;
    int done0;
    int nbytes;
    int wr0 [0:`VLSU_VLMAX-1];
    logic [`VLSU_ADDR_W-1:0] a;
    logic [`VLSU_DATA_W-1:0] exp;
    begin
      acc0   = u_mem.log_cnt;
      done0  = done_cnt;
      nbytes = elem_bytes(c.eew);
      for (int k = 0; k < `VLSU_VLMAX; k++)
        wr0[5'(k)] = wr_count[5'(k)];
      cmd       = c;
      cmd_start = 1'b1;
      tick();
      cmd_start   = 1'b0;
      started_cnt = started_cnt + 1;
      // a second start while busy must be dropped or it would store at 0x380
      if (overlap)
      begin
        repeat (3) tick();
        cmd       = make_cmd(1'b1, WIDTH32, 32'h380, `VLSU_SIZE32, 5);
        cmd_start = 1'b1;
        tick();
        cmd_start = 1'b0;
      end
      while (done_cnt == done0)
        tick();
      tick();
      check_hex("access count", 128'(u_mem.log_cnt - acc0), 128'(c.vl));
      for (int k = 0; k < int'(c.vl); k++)
      begin
        a   = c.base + 32'(k) * c.stride;
        exp = '0;
        // elements are issued in index order with one access each
        check_hex($sformatf("mem_req.addr of element %0d", k),
                  128'(u_mem.log_addr[8'(acc0 + k)]), 128'(a));
        check_hex($sformatf("mem_req.byte_en of element %0d", k),
                  128'(u_mem.log_be[8'(acc0 + k)]), 128'(((1 << nbytes) - 1) << a[1:0]));
        check_hex($sformatf("mem_req.ren and wen of element %0d", k),
                  128'(u_mem.log_rw[8'(acc0 + k)]), 128'(c.store ? 2'b01 : 2'b10));
        // little endian element bytes starting at the element address
        for (int b = 0; b < nbytes; b++)
        begin
          if (c.store)
            ref_mem[a[9:0] + 10'(b)] = vreg_src[5'(k)][8*b +: 8];
          else
            exp[8*b +: 8] = ref_mem[a[9:0] + 10'(b)];
        end
        if (!c.store)
          check_hex($sformatf("vreg_wr.data[%0d]", k), 128'(wr_val[5'(k)]), 128'(exp));
      end
      for (int k = 0; k < `VLSU_VLMAX; k++)
        check_hex($sformatf("write count of v[%0d]", k), 128'(wr_count[5'(k)] - wr0[5'(k)]),
                  128'((k < int'(c.vl) && !c.store) ? 1 : 0));
      a = c.base + 32'(c.vl) * c.stride;
      for (int j = acc0; j < u_mem.log_cnt; j++)
        check_true(u_mem.log_addr[8'(j)] != a, "memory was accessed for the element at index vl");
      for (int i = 0; i < 1024; i++)
        check_hex($sformatf("mem[0x%0h]", i), 128'(u_mem.mem[10'(i)]), 128'(ref_mem[10'(i)]));
      repeat (4) tick();
      check_hex("done count", 128'(done_cnt), 128'(done0 + 1));
      check_hex("access count after done", 128'(u_mem.log_cnt - acc0), 128'(c.vl));
    end
  endtask

  // a misaligned command has to park in the exception state without any access
  task automatic run_misaligned(input vlsu_cmd_t c);
    int acc0;
    int done0;
    begin
      acc0      = u_mem.log_cnt;
      done0     = done_cnt;
      cmd       = c;
      cmd_start = 1'b1;
      tick();
      cmd_start = 1'b0;
      @(negedge CLK);
      while (!exception)
        @(negedge CLK);
      repeat (5)
      begin
        check_true(exception, "exception fell before it was cleared");
        check_hex("busy", 128'(busy), 128'(0));
        check_hex("mem_req.ren", 128'(mem_req.ren), 128'(0));
        check_hex("mem_req.wen", 128'(mem_req.wen), 128'(0));
        @(negedge CLK);
      end
      tick();
      ex_clear = 1'b1;
      tick();
      ex_clear = 1'b0;
      @(negedge CLK);
      check_hex("exception", 128'(exception), 128'(0));
      check_hex("busy", 128'(busy), 128'(0));
      check_hex("accesses of the misaligned command", 128'(u_mem.log_cnt - acc0), 128'(0));
      check_hex("done count", 128'(done_cnt), 128'(done0));
      tick();
    end
  endtask

  initial
  begin
    nRST      = 1'b0;
    cmd_start = 1'b0;
    ex_clear  = 1'b0;
    cmd       = '0;
    // store sources follow a pattern over the whole index
    for (int i = 0; i < `VLSU_VLMAX; i++)
      vreg_src[5'(i)] = 32'h6A09_E667 ^ (32'(i) * 32'h0105_0B13);
    repeat (16) @(posedge CLK);
    #1;
    nRST = 1'b1;
    for (int a = 0; a < 1024; a++)
      ref_mem[10'(a)] = u_mem.mem[10'(a)];
    repeat (3)
    begin
      @(negedge CLK);
      check_hex("mem_req.ren", 128'(mem_req.ren), 128'(0));
      check_hex("mem_req.wen", 128'(mem_req.wen), 128'(0));
      check_hex("busy", 128'(busy), 128'(0));
      check_hex("done", 128'(done), 128'(0));
      check_hex("exception", 128'(exception), 128'(0));
      check_hex("vreg_wr.wen", 128'(vreg_wr.wen), 128'(0));
    end
    tick();
    run_cmd(make_cmd(1'b0, WIDTH32, 32'h100, `VLSU_SIZE32, VL_U32), 1'b1);
    run_cmd(make_cmd(1'b0, WIDTH8, 32'h041, 32'd3, VL_S8), 1'b0);
    run_cmd(make_cmd(1'b1, WIDTH16, 32'h202, 32'd6, VL_ST16), 1'b0);
    run_misaligned(make_cmd(1'b0, WIDTH32, 32'h301, `VLSU_SIZE32, VL_BAD));
    run_cmd(make_cmd(1'b0, WIDTH16, 32'h080, `VLSU_SIZE16, VL_L16), 1'b0);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlsu.f
+incdir+include
rtl/vlsu_pkg.sv
rtl/vlsu_addr_gen.sv
rtl/address_scheduler.sv
rtl/vlsu_load_align.sv
rtl/vlsu.sv
testbench/tb_vlsu_mem.sv
testbench/tb_vlsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the vlsu testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlsu.f --top-module tb_vlsu -o tb_vlsu > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_vlsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "NO ERRORS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
